/* design/render_settings.svh */
// Renderer settings
`ifndef RENDER_SETTINGS_SVH
`define RENDER_SETTINGS_SVH

`define H_RES          320      // active pixels per line
`define V_RES          240      // active lines per frame
`define H_FP           23
`define H_SYNC         28
`define H_BP           45
`define V_FP           6
`define V_SYNC         3
`define V_BP           20
`define H_POL          1'b0     // 0 for active low
`define V_POL          1'b0
`define H_BLANK        (`H_FP + `H_SYNC + `H_BP)
`define H_TOTAL        (`H_BLANK + `H_RES)
`define V_BLANK        (`V_FP + `V_SYNC + `V_BP)
`define V_TOTAL        (`V_BLANK + `V_RES)

`define TILE_PX        8

`define BG_MAP_BASE    0        // vram8
`define BG_COLOR_BASE  2048
`define WIN_MAP_BASE   4096
`define WIN_COLOR_BASE 6144
`define PALETTE_BASE   1024     // vram32

`define FETCH_LEAD     10       // fetch starts this far before the column
`define PIPE_DELAY     3        // counter to o_rgb

`endif

/* design/video_timing_pkg.sv */
// Raster timing types
`default_nettype none

package video_timing_pkg;

    typedef struct packed {
        logic [9:0] h;      // line position incl. blanking
        logic [8:0] v;      // frame position incl. blanking
        logic       de;
        logic       hs;
        logic       vs;
    } raster_pos_t;

    // blanked position with both syncs idle
    function automatic raster_pos_t blank_pos(input logic hs_pol, input logic vs_pol);
        blank_pos    = '0;
        blank_pos.hs = ~hs_pol;
        blank_pos.vs = ~vs_pol;
    endfunction

endpackage

`default_nettype wire

/* design/tile_pkg.sv */
// Tile plane types
`default_nettype none

package tile_pkg;

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb332_t;

    typedef enum logic [2:0] {
        bg_map,
        bg_pattern,
        bg_color,
        bg_palette,
        win_map,
        win_pattern,
        win_color,
        win_palette
    } fetch_phase_t;

    typedef struct packed {
        logic [15:0] hi;    // even tile lines
        logic [15:0] lo;    // odd tile lines
    } pattern_word_t;

    // one vram32 word, either a pattern row pair or four palette entries
    typedef union packed {
        pattern_word_t  pattern;
        rgb332_t [0:3]  palette;    // entry 0 in 31:24
    } vram32_word_u;

    typedef struct packed {
        vram32_word_u bg_pattern;
        vram32_word_u bg_palette;
        vram32_word_u win_pattern;
        vram32_word_u win_palette;
        logic         line_odd;
    } tile_words_t;

    typedef rgb332_t [7:0] tile_pixels_t;   // pixel k at [k]

    typedef struct packed {
        tile_pixels_t bg;
        tile_pixels_t win;
    } tile_line_t;

endpackage

`default_nettype wire

/* design/video_timing.sv */
// Raster timing generator
`default_nettype none
`include "render_settings.svh"

module video_timing
    import video_timing_pkg::*;
(
    input  logic        vga_clk,
    input  logic        i_reset,
    output raster_pos_t o_pos
);

    logic [9:0] h_cnt;
    logic [8:0] v_cnt;
    logic       h_last;
    logic       v_last;
    logic       hs;
    logic       vs;
    logic       de;

    assign h_last = (h_cnt == 10'(`H_TOTAL - 1));
    assign v_last = (v_cnt == 9'(`V_TOTAL - 1));

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 9'd1;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    assign hs = (h_cnt >= `H_FP && h_cnt < `H_FP + `H_SYNC) ? `H_POL : ~`H_POL;
    assign vs = (v_cnt >= `V_FP && v_cnt < `V_FP + `V_SYNC) ? `V_POL : ~`V_POL;
    assign de = (h_cnt >= `H_BLANK) && (v_cnt >= `V_BLANK);  // active area is at the end

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            o_pos <= blank_pos(`H_POL, `V_POL);
        end else begin
            o_pos <= '{h: h_cnt, v: v_cnt, de: de, hs: hs, vs: vs};
        end
    end

    a_no_de_in_sync: assert property (@(posedge vga_clk) disable iff (i_reset)
        o_pos.de |-> (o_pos.hs == ~`H_POL) && (o_pos.vs == ~`V_POL));

endmodule

`default_nettype wire

/* design/tile_fetch.sv */
// Tile column fetch sequencer
`default_nettype none
`include "render_settings.svh"

module tile_fetch
    import video_timing_pkg::*;
    import tile_pkg::*;
(
    input  logic         vga_clk,
    input  logic         i_reset,
    input  raster_pos_t  i_pos,
    input  logic [7:0]   i_vram8_q,
    input  vram32_word_u i_vram32_q,
    output logic [13:0]  o_vram8_addr,
    output logic [13:0]  o_vram32_addr,
    output tile_words_t  o_words,
    output logic         o_words_valid
);

    localparam int FETCH_START = `H_BLANK - `FETCH_LEAD;
    localparam int MAP_COLS    = `H_RES / `TILE_PX;

    logic [9:0]   fetch_h;
    logic [8:0]   line_v;
    logic         in_window;
    fetch_phase_t phase;
    fetch_phase_t phase_q;
    logic         active_q;
    logic [5:0]   col;
    logic [4:0]   row;
    logic [2:0]   tile_line;
    logic [13:0]  map_offset;

    // fetch position runs FETCH_LEAD ahead of the pixel position
    assign fetch_h   = i_pos.h - 10'(FETCH_START);
    assign line_v    = i_pos.v - 9'(`V_BLANK);
    assign in_window = (i_pos.h >= 10'(FETCH_START)) &&
                       (i_pos.h < 10'(FETCH_START + `H_RES)) &&
                       (i_pos.v >= 9'(`V_BLANK));

    assign phase      = fetch_phase_t'(fetch_h[2:0]);
    assign col        = fetch_h[8:3];
    assign row        = line_v[7:3];
    assign tile_line  = line_v[2:0];
    assign map_offset = 14'(row * MAP_COLS + col);

    // pattern and palette phases use the vram8 word of the phase before
    always_comb begin
        o_vram8_addr  = '0;
        o_vram32_addr = '0;
        if (in_window) begin
            case (phase)
                bg_map:      o_vram8_addr = 14'(`BG_MAP_BASE) + map_offset;
                bg_color:    o_vram8_addr = 14'(`BG_COLOR_BASE) + map_offset;
                win_map:     o_vram8_addr = 14'(`WIN_MAP_BASE) + map_offset;
                win_color:   o_vram8_addr = 14'(`WIN_COLOR_BASE) + map_offset;
                bg_pattern,
                win_pattern: o_vram32_addr = {4'b0, i_vram8_q, 2'b00} + 14'(tile_line[2:1]);
                bg_palette,
                win_palette: o_vram32_addr = 14'(`PALETTE_BASE) + 14'(i_vram8_q);
                default:     o_vram8_addr = '0;
            endcase
        end
    end

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            active_q      <= 1'b0;
            phase_q       <= bg_map;
            o_words_valid <= 1'b0;
        end else begin
            active_q      <= in_window;
            phase_q       <= phase;
            o_words_valid <= active_q && (phase_q == win_palette);  // last word lands
        end
    end

    always_ff @(posedge vga_clk) begin
        if (active_q) begin
            case (phase_q)
                bg_pattern:  o_words.bg_pattern  <= i_vram32_q;
                bg_palette:  o_words.bg_palette  <= i_vram32_q;
                win_pattern: o_words.win_pattern <= i_vram32_q;
                win_palette: begin
                    o_words.win_palette <= i_vram32_q;
                    o_words.line_odd    <= tile_line[0];
                end
                default: ;
            endcase
        end
    end

    a_valid_spacing: assert property (@(posedge vga_clk) disable iff (i_reset)
        o_words_valid |=> !o_words_valid [*7]);

endmodule

`default_nettype wire

/* design/pattern_decode.sv */
// Tile line pattern decoder
`default_nettype none

module pattern_decode
    import tile_pkg::*;
(
    input  logic        vga_clk,
    input  logic        i_reset,
    input  tile_words_t i_words,
    input  logic        i_words_valid,
    output tile_line_t  o_line,
    output logic        o_line_valid
);

    // reversed word, so odd lines end up with the flipped low half
    function automatic tile_pixels_t decode_plane(
        input vram32_word_u pat_word,
        input vram32_word_u pal_word,
        input logic         line_odd
    );
        logic [15:0] half;
        logic [15:0] idx;
        half = line_odd ? pat_word.pattern.lo : pat_word.pattern.hi;
        idx  = {<<{half}};
        for (int k = 0; k < 8; k++) begin
            decode_plane[k] = pal_word.palette[idx[2*k +: 2]];  // index 0 is bits 31:24
        end
    endfunction

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            o_line_valid <= 1'b0;
        end else begin
            o_line_valid <= i_words_valid;
        end
    end

    always_ff @(posedge vga_clk) begin
        if (i_words_valid) begin
            o_line.bg  <= decode_plane(i_words.bg_pattern, i_words.bg_palette,
                                       i_words.line_odd);
            o_line.win <= decode_plane(i_words.win_pattern, i_words.win_palette,
                                       i_words.line_odd);
        end
    end

endmodule

`default_nettype wire

/* design/plane_mixer.sv */
// Background and window mixer
`default_nettype none
`include "render_settings.svh"

module plane_mixer
    import video_timing_pkg::*;
    import tile_pkg::*;
(
    input  logic        vga_clk,
    input  logic        i_reset,
    input  raster_pos_t i_pos,
    input  tile_line_t  i_line,
    input  logic        i_line_valid,
    output rgb332_t     o_rgb
);

    tile_line_t cur_line;
    logic [9:0] act_x;
    logic [2:0] sel;
    rgb332_t    win_px;
    rgb332_t    bg_px;

    always_ff @(posedge vga_clk) begin
        if (i_line_valid) begin
            cur_line <= i_line;
        end
    end

    assign act_x  = i_pos.h - 10'(`H_BLANK);
    assign sel    = act_x[2:0];     // pixel within tile
    assign win_px = cur_line.win[sel];
    assign bg_px  = cur_line.bg[sel];

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            o_rgb <= '0;
        end else if (!i_pos.de) begin
            o_rgb <= '0;
        end else if (win_px != '0) begin
            o_rgb <= win_px;
        end else begin
            o_rgb <= bg_px;     // black window is see-through
        end
    end

endmodule

`default_nettype wire

/* design/bgw_renderer.sv */
// Background and window renderer
`default_nettype none
`include "render_settings.svh"

module bgw_renderer
    import video_timing_pkg::*;
    import tile_pkg::*;
(
    input  logic        vga_clk,
    input  logic        i_reset,
    input  logic [7:0]  i_vram8_q,
    input  logic [31:0] i_vram32_q,
    output logic [13:0] o_vram8_addr,
    output logic [13:0] o_vram32_addr,
    output logic        o_hs,
    output logic        o_vs,
    output logic        o_de,
    output rgb332_t     o_rgb
);

    // o_pos already carries one register from the counters
    localparam int POS_STAGES = `PIPE_DELAY - 1;

    raster_pos_t  pos;
    raster_pos_t  pos_pipe [POS_STAGES];
    vram32_word_u vram32_word;
    tile_words_t  words;
    logic         words_valid;
    tile_line_t   line;
    logic         line_valid;

    assign vram32_word = i_vram32_q;

    video_timing u_timing (
        .vga_clk (vga_clk),
        .i_reset (i_reset),
        .o_pos   (pos)
    );

    tile_fetch u_fetch (
        .vga_clk       (vga_clk),
        .i_reset       (i_reset),
        .i_pos         (pos),
        .i_vram8_q     (i_vram8_q),
        .i_vram32_q    (vram32_word),
        .o_vram8_addr  (o_vram8_addr),
        .o_vram32_addr (o_vram32_addr),
        .o_words       (words),
        .o_words_valid (words_valid)
    );

    pattern_decode u_decode (
        .vga_clk       (vga_clk),
        .i_reset       (i_reset),
        .i_words       (words),
        .i_words_valid (words_valid),
        .o_line        (line),
        .o_line_valid  (line_valid)
    );

    // mixer runs one position behind so each new line lands on its first pixel
    plane_mixer u_mixer (
        .vga_clk      (vga_clk),
        .i_reset      (i_reset),
        .i_pos        (pos_pipe[0]),
        .i_line       (line),
        .i_line_valid (line_valid),
        .o_rgb        (o_rgb)
    );

    always_ff @(posedge vga_clk) begin
        if (i_reset) begin
            for (int i = 0; i < POS_STAGES; i++) begin
                pos_pipe[i] <= blank_pos(`H_POL, `V_POL);
            end
        end else begin
            pos_pipe[0] <= pos;
            for (int i = 1; i < POS_STAGES; i++) begin
                pos_pipe[i] <= pos_pipe[i-1];
            end
        end
    end

    assign o_hs = pos_pipe[POS_STAGES-1].hs;    // aligned with o_rgb
    assign o_vs = pos_pipe[POS_STAGES-1].vs;
    assign o_de = pos_pipe[POS_STAGES-1].de;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Clock and reset generator
`default_nettype none

module tb_clock_gen (
    output logic o_vga_clk,
    output logic o_reset
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;    // 8 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        o_vga_clk = 1'b0;
        forever #(HALF_PERIOD) o_vga_clk = ~o_vga_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_vga_clk);
        #1;
        o_reset = 1'b0;     // drops just after the edge
    end

endmodule

`default_nettype wire

/* testbench/vram_model.sv */
// VRAM model
`default_nettype none

module vram_model (
    input  logic        vga_clk,
    input  logic [13:0] i_addr8,
    input  logic [13:0] i_addr32,
    output logic [7:0]  o_q8,
    output logic [31:0] o_q32
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 16384;

    logic [7:0]  mem8  [DEPTH];
    logic [31:0] mem32 [DEPTH];
    logic [13:0] addr8_s;
    logic [13:0] addr32_s;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem8[i]  = '0;
            mem32[i] = '0;
        end
        o_q8  = '0;
        o_q32 = '0;
    end

    // address taken at the edge, data shows up 1 ns later
    always @(posedge vga_clk) begin
        addr8_s  = i_addr8;
        addr32_s = i_addr32;
        #1;
        o_q8  = mem8[addr8_s];
        o_q32 = mem32[addr32_s];
    end

    task automatic write8(input logic [13:0] addr, input logic [7:0] data);
        mem8[addr] = data;
    endtask

    task automatic write32(input logic [13:0] addr, input logic [31:0] data);
        mem32[addr] = data;
    endtask

endmodule

`default_nettype wire

/* testbench/bgw_renderer_tb.sv */
// Renderer testbench
`default_nettype none
`include "render_settings.svh"

module bgw_renderer_tb
    import tile_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_ENTRIES   = 64;
    localparam int RESET_TIMEOUT = 64;
    localparam int LINE_TIMEOUT  = 2 * `H_TOTAL;
    localparam int FRAME_TIMEOUT = 2 * `H_TOTAL * `V_TOTAL;

    logic        vga_clk;
    logic        i_reset;
    logic [7:0]  vram8_q;
    logic [31:0] vram32_q;
    logic [13:0] vram8_addr;
    logic [13:0] vram32_addr;
    logic        hs;
    logic        vs;
    logic        de;
    rgb332_t     rgb;

    logic [63:0] entries [MAX_ENTRIES];
    int          chk_x [$];
    int          chk_y [$];
    logic [7:0]  chk_rgb [$];
    int          next_chk;
    int          pixel_checks;
    int          value_errors;
    int          other_errors;
    logic        monitor_on;

    tb_clock_gen clock_gen (
        .o_vga_clk (vga_clk),
        .o_reset   (i_reset)
    );

    vram_model vram (
        .vga_clk  (vga_clk),
        .i_addr8  (vram8_addr),
        .i_addr32 (vram32_addr),
        .o_q8     (vram8_q),
        .o_q32    (vram32_q)
    );

    bgw_renderer UUT (
        .vga_clk       (vga_clk),
        .i_reset       (i_reset),
        .i_vram8_q     (vram8_q),
        .i_vram32_q    (vram32_q),
        .o_vram8_addr  (vram8_addr),
        .o_vram32_addr (vram32_addr),
        .o_hs          (hs),
        .o_vs          (vs),
        .o_de          (de),
        .o_rgb         (rgb)
    );

    task automatic report_value(input string msg);
        value_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("pixel checks %0d, value errors %0d, other errors %0d",
                 pixel_checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        other_errors++;
        $display("Timed out at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic next_cycle();
        @(negedge vga_clk);     // outputs settled
    endtask

    task automatic wait_for_vs(input logic level);
        int n;
        n = 0;
        while (vs !== level) begin
            assert (de === 1'b0) else report_value("o_de high before the first active line");
            if (n >= FRAME_TIMEOUT) begin
                abort_on_timeout("o_vs");
            end
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_for_de(input int y);
        int n;
        int limit;
        int hs_cycles;
        n         = 0;
        hs_cycles = 0;
        limit     = (y == 0) ? FRAME_TIMEOUT : LINE_TIMEOUT;   // first line after back porch
        while (de !== 1'b1) begin
            if (hs === `H_POL) begin
                hs_cycles++;
            end
            if (n >= limit) begin
                abort_on_timeout($sformatf("o_de to rise on line %0d", y));
            end
            next_cycle();
            n++;
        end
        if (y > 0) begin
            assert (hs_cycles == `H_SYNC) else
                report_value($sformatf("o_hs pulse before line %0d is %0d cycles",
                                       y, hs_cycles));
        end
    endtask

    // walks one active line, comparing the listed positions
    task automatic scan_line(input int y);
        int x;
        x = 0;
        while (de === 1'b1) begin
            if (next_chk < chk_x.size() && chk_y[next_chk] == y && chk_x[next_chk] == x) begin
                pixel_checks++;
                assert (rgb == chk_rgb[next_chk]) else
                    report_value($sformatf("pixel (%0d,%0d) is %h, expected %h",
                                           x, y, rgb, chk_rgb[next_chk]));
                next_chk++;
            end
            if (x >= LINE_TIMEOUT) begin
                abort_on_timeout($sformatf("o_de to fall on line %0d", y));
            end
            next_cycle();
            x++;
        end
        assert (x == `H_RES) else
            report_value($sformatf("line %0d has %0d active pixels", y, x));
    endtask

    task automatic apply_entries();
        logic [3:0]  kind;
        logic [15:0] a;
        logic [11:0] b;
        logic [31:0] d;
        for (int i = 0; i < MAX_ENTRIES; i++) begin
            {kind, a, b, d} = entries[i];
            case (kind)
                4'h0: ;                             // unused slot
                4'h1: vram.write8(a[13:0], d[7:0]);
                4'h2: vram.write32(a[13:0], d);
                4'h3: begin
                    chk_x.push_back(int'(a));
                    chk_y.push_back(int'(b));
                    chk_rgb.push_back(d[7:0]);
                end
                default: begin
                    other_errors++;
                    $display("Unknown entry kind %h in the tests file", kind);
                end
            endcase
        end
    endtask

    // blanking and sync rules on every cycle after reset
    always @(negedge vga_clk) begin
        if (monitor_on) begin
            assert (de || rgb == '0) else
                report_value($sformatf("o_rgb is %h while o_de is low", rgb));
            assert (!(de && (hs == `H_POL || vs == `V_POL))) else
                report_value("o_de high during a sync pulse");
        end
    end

    initial begin
        int n;
        pixel_checks = 0;
        value_errors = 0;
        other_errors = 0;
        next_chk     = 0;
        monitor_on   = 1'b0;
        for (int i = 0; i < MAX_ENTRIES; i++) begin
            entries[i] = '0;
        end
        $readmemh("testbench/render_tests.txt", entries);

        @(posedge vga_clk);     // vram model cleared by now
        apply_entries();

        n = 0;
        while (i_reset !== 1'b0) begin
            if (n >= RESET_TIMEOUT) begin
                abort_on_timeout("reset release");
            end
            next_cycle();
            n++;
        end

        assert (de === 1'b0 && rgb == '0) else report_value("o_de or o_rgb set after reset");
        assert (hs === ~`H_POL && vs === ~`V_POL) else
            report_value("sync outputs active after reset");
        monitor_on = 1'b1;

        wait_for_vs(`V_POL);
        wait_for_vs(~`V_POL);
        for (int y = 0; y < `V_RES; y++) begin
            wait_for_de(y);
            scan_line(y);
        end

        if (next_chk < chk_x.size()) begin
            other_errors++;
            $display("%0d listed pixel positions were never reached", chk_x.size() - next_chk);
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/video_timing_pkg.sv
design/tile_pkg.sv
design/video_timing.sv
design/tile_fetch.sv
design/pattern_decode.sv
design/plane_mixer.sv
design/bgw_renderer.sv
testbench/tb_clock_gen.sv
testbench/vram_model.sv
testbench/bgw_renderer_tb.sv

/* testbench/render_tests.txt */
// k_aaaa_bbb_dddddddd  k=1 vram8 write, k=2 vram32 write: a=address, d=data
// k=3 pixel check: a=x, b=y, d=expected rgb332 (window transparent unless set)
1_0000_000_00000001 // bg map r0 c0, tile 1
1_0800_000_00000001 // bg colour r0 c0, palette 1
2_0004_000_27D8A5F0 // tile 1 lines 0 and 1
2_0401_000_49E01C03 // palette 1
1_007D_000_00000002 // bg map r3 c5, tile 2
1_087D_000_00000002 // bg colour r3 c5, palette 2
2_0009_000_0000D827 // tile 2 lines 2 and 3
2_0402_000_00FF9224 // palette 2
1_0032_000_00000003 // bg map r1 c10, tile 3
1_0832_000_00000003 // bg colour r1 c10, palette 3
1_1032_000_00000004 // win map r1 c10, tile 4
1_1832_000_00000004 // win colour r1 c10, palette 4
2_0403_000_6D6D6D6D // palette 3, flat grey
2_0404_000_00FC1FE3 // palette 4, entry 0 see-through
2_0010_000_21300000 // tile 4 lines 0 and 1
3_0000_000_00000049
3_0001_000_000000E0
3_0003_000_00000003
3_0007_000_00000049
3_0028_000_00000000
3_0002_001_0000001C
3_0006_001_00000049
3_0050_008_0000006D
3_0051_008_000000FC
3_0052_008_0000006D
3_0053_008_0000001F
3_0055_008_000000E3
3_0000_01B_00000000
3_0027_01B_00000000
3_0028_01B_00000024
3_0029_01B_00000092
3_002A_01B_000000FF
3_002B_01B_00000000
3_002F_01B_00000024
3_0030_01B_00000000
3_013F_0EF_00000000
